/* sources.f */
common/game_pkg.sv
src/screen_fill.sv
playing/sprite_fill.sv
playing/scan_out.sv
playing/frame_sequencer.sv
src/game_sequencer.sv
test/tb_frame_ram.sv
test/tb_game_sequencer.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal --top-module tb_game_sequencer -f sources.f \
    -o sim_game_sequencer
./obj_dir/sim_game_sequencer > sim.log 2>&1
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

/* test/tb_game_sequencer.sv */
`timescale 1ns/1ps

module tb_game_sequencer;

    localparam int SCREEN_W     = 16;
    localparam int SCREEN_H     = 12;
    localparam int PLAYER_SIZE  = 8;
    localparam int PIXELS       = SCREEN_W * SCREEN_H;
    localparam int TIMEOUT      = 1000;    // Cycles allowed for any one wait
    localparam int STALL_CYCLES = 100;

    logic               clock;
    logic               resetn;
    logic               enable;
    game_pkg::vga_x_t   player_x;
    game_pkg::vga_y_t   player_y;
    game_pkg::fb_addr_t addr;
    game_pkg::color_t   data;
    logic               wren;
    game_pkg::color_t   q;
    game_pkg::vga_x_t   vga_x;
    game_pkg::vga_y_t   vga_y;
    game_pkg::color_t   vga_color;
    logic               plot;

    int          checks;
    int          value_errors;
    int          other_errors;
    logic [31:0] rng;

    game_sequencer #(
        .SCREEN_W    (SCREEN_W),
        .SCREEN_H    (SCREEN_H),
        .PLAYER_SIZE (PLAYER_SIZE)
    ) i_game_sequencer (
        .clock     (clock),
        .resetn    (resetn),
        .enable    (enable),
        .player_x  (player_x),
        .player_y  (player_y),
        .addr      (addr),
        .data      (data),
        .wren      (wren),
        .q         (q),
        .vga_x     (vga_x),
        .vga_y     (vga_y),
        .vga_color (vga_color),
        .plot      (plot)
    );

    tb_frame_ram i_frame_ram (
        .clock (clock),
        .addr  (addr),
        .data  (data),
        .wren  (wren),
        .q     (q)
    );

    always #10 clock = ~clock;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic finish_run();
        $display("Summary: %0d checks, %0d value errors, %0d other failures",
                 checks, value_errors, other_errors);
        if (value_errors + other_errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    endtask

    task automatic check_color(input string name, input game_pkg::color_t exp,
                               input game_pkg::color_t act);
        checks++;
        if (act !== exp) begin
            value_errors++;
            $display("ERROR %s: color expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input game_pkg::fb_addr_t exp,
                              input game_pkg::fb_addr_t act);
        checks++;
        if (act !== exp) begin
            value_errors++;
            $display("ERROR %s: address expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_pixel(input string name, input game_pkg::vga_x_t exp_x,
                               input game_pkg::vga_y_t exp_y, input game_pkg::color_t exp_c,
                               input game_pkg::vga_x_t act_x, input game_pkg::vga_y_t act_y,
                               input game_pkg::color_t act_c);
        checks++;
        if (act_x !== exp_x || act_y !== exp_y || act_c !== exp_c) begin
            value_errors++;
            $display("ERROR %s: pixel expected (%0d,%0d) %h, actual (%0d,%0d) %h",
                     name, exp_x, exp_y, exp_c, act_x, act_y, act_c);
        end
    endtask

    // Next falling edge with a write or a plot
    // Strict mode allows no gap
    task automatic wait_event(input string name, input bit want_plot, input bit strict);
        int                    n;
        game_pkg::game_state_t phase;
        n = 0;
        @(negedge clock);
        while (!(want_plot ? plot : wren) && !strict && n < TIMEOUT) begin
            if (want_plot && wren) begin
                other_errors++;
                $display("%s: frame buffer written while waiting for scan out", name);
            end
            @(negedge clock);
            n++;
        end
        if (!(want_plot ? plot : wren)) begin
            other_errors++;
            phase = i_game_sequencer.state;
            if (strict) begin
                $display("%s: a %s is missing from a back-to-back run", name,
                         want_plot ? "plot" : "write");
            end else begin
                $display("%s: timed out after %0d cycles waiting for a %s in phase %s",
                         name, TIMEOUT, want_plot ? "plot" : "write", phase.name());
                finish_run();
            end
        end
    endtask

    // Whole-screen fill with one write per cycle in raster order
    task automatic check_fill(input string name, input game_pkg::color_t color,
                              input int first);
        for (int i = first; i < PIXELS; i++) begin
            wait_event(name, 1'b0, i != first);
            check_addr(name, game_pkg::fb_addr_t'(i), addr);
            check_color(name, color, data);
        end
    endtask

    task automatic check_frame(input string name, input int px, input int py,
                               input int first_clear);
        int   sx;
        int   sy;
        logic in_square;
        check_fill(name, game_pkg::COLOR_BACKGROUND, first_clear);
        // Sprite writes skip whatever falls off the screen
        for (int dy = 0; dy < PLAYER_SIZE; dy++) begin
            for (int dx = 0; dx < PLAYER_SIZE; dx++) begin
                sx = px + dx;
                sy = py + dy;
                if (sx < SCREEN_W && sy < SCREEN_H) begin
                    wait_event(name, 1'b0, 1'b0);
                    check_addr(name, game_pkg::fb_addr_t'(sy * SCREEN_W + sx), addr);
                    check_color(name, game_pkg::COLOR_PLAYER, data);
                end
            end
        end
        for (int i = 0; i < PIXELS; i++) begin
            sx = i % SCREEN_W;
            sy = i / SCREEN_W;
            in_square = (sx >= px) && (sx < px + PLAYER_SIZE) &&
                        (sy >= py) && (sy < py + PLAYER_SIZE);
            wait_event(name, 1'b1, i != 0);
            check_pixel(name, game_pkg::vga_x_t'(sx), game_pkg::vga_y_t'(sy),
                        in_square ? game_pkg::COLOR_PLAYER : game_pkg::COLOR_BACKGROUND,
                        vga_x, vga_y, vga_color);
            if (wren) begin
                other_errors++;
                $display("%s: frame buffer written during scan out", name);
            end
        end
    endtask

    task automatic test_reset();
        resetn = 1'b0;
        repeat (3) begin
            @(negedge clock);
            if (wren !== 1'b0 || plot !== 1'b0) begin
                other_errors++;
                $display("reset: wren or plot is not low while reset is asserted");
            end
        end
        resetn = 1'b1;
        check_fill("reset", game_pkg::COLOR_GREETING, 0);
    endtask

    task automatic test_playing_frame();
        int px;
        int py;
        rng = xorshift(rng);
        px = int'(rng % (SCREEN_W - PLAYER_SIZE + 1));    // Fully on screen
        rng = xorshift(rng);
        py = int'(rng % (SCREEN_H - PLAYER_SIZE + 1));
        player_x = game_pkg::vga_x_t'(px);
        player_y = game_pkg::vga_y_t'(py);
        check_frame("playing", px, py, 0);
    endtask

    task automatic test_game_over_loop();
        check_fill("game_over", game_pkg::COLOR_GAME_OVER, 0);
        wait_event("loop", 1'b0, 1'b0);
        check_addr("loop", '0, addr);
        check_color("loop", game_pkg::COLOR_GREETING, data);
    endtask

    task automatic test_stall();
        enable = 1'b0;    // Greeting still has most of its walk ahead
        check_fill("stall", game_pkg::COLOR_GREETING, 1);
        repeat (STALL_CYCLES) begin
            @(negedge clock);
            if (wren || plot) begin
                other_errors++;
                $display("stall: write or plot seen while enable is low");
            end
        end
        enable = 1'b1;
        wait_event("stall", 1'b0, 1'b0);
        check_addr("stall", '0, addr);
        check_color("stall", game_pkg::COLOR_BACKGROUND, data);
    endtask

    // Position changes while the clear runs and the sprite latches it later
    task automatic test_clipping();
        int px;
        int py;
        rng = xorshift(rng);
        px = SCREEN_W - 7 + int'(rng % 7);
        rng = xorshift(rng);
        py = SCREEN_H - 7 + int'(rng % 7);
        player_x = game_pkg::vga_x_t'(px);
        player_y = game_pkg::vga_y_t'(py);
        check_frame("clipping", px, py, 1);
    endtask

    initial begin
        clock        = 1'b0;
        resetn       = 1'b0;
        enable       = 1'b1;
        player_x     = '0;
        player_y     = '0;
        checks       = 0;
        value_errors = 0;
        other_errors = 0;
        rng          = 32'd60605;
        test_reset();
        test_playing_frame();
        test_game_over_loop();
        test_stall();
        test_clipping();
        finish_run();
    end

endmodule

/* test/tb_frame_ram.sv */
`timescale 1ns/1ps

module tb_frame_ram #(
    parameter int AW = 8    // 256 words, plenty for the small test screen
) (
    input  logic               clock,
    input  game_pkg::fb_addr_t addr,
    input  game_pkg::color_t   data,
    input  logic               wren,
    output game_pkg::color_t   q
);

    game_pkg::color_t mem [0:(1<<AW)-1];

    // One write port, registered read
    always_ff @(posedge clock) begin
        if (wren)
            mem[addr[AW-1:0]] <= data;
        q <= mem[addr[AW-1:0]];    // Old word on a read during write
    end

endmodule

/* src/game_sequencer.sv */
`timescale 1ns/1ps

module game_sequencer #(
    parameter int SCREEN_W    = game_pkg::DEFAULT_SCREEN_W,
    parameter int SCREEN_H    = game_pkg::DEFAULT_SCREEN_H,
    parameter int PLAYER_SIZE = game_pkg::DEFAULT_PLAYER_SIZE
) (
    input  logic               clock,
    input  logic               resetn,
    input  logic               enable,
    input  game_pkg::vga_x_t   player_x,
    input  game_pkg::vga_y_t   player_y,
    output game_pkg::fb_addr_t addr,
    output game_pkg::color_t   data,
    output logic               wren,
    input  game_pkg::color_t   q,
    output game_pkg::vga_x_t   vga_x,
    output game_pkg::vga_y_t   vga_y,
    output game_pkg::color_t   vga_color,
    output logic               plot
);

    game_pkg::game_state_t state, next_state;

    logic e_greeting, e_playing, e_game_over;
    logic f_greeting, f_playing, f_game_over;

    game_pkg::fb_addr_t ad_greeting, ad_playing, ad_game_over;
    game_pkg::color_t   dt_greeting, dt_playing, dt_game_over;
    logic               wr_greeting, wr_playing, wr_game_over;

    // Phase register, moves only when the outside world allows it
    always_ff @(posedge clock) begin
        if (!resetn)
            state <= game_pkg::GREETING;
        else if (enable)
            state <= next_state;
    end

    always_comb begin
        next_state = state;
        case (state)
            game_pkg::GREETING:  if (f_greeting)  next_state = game_pkg::PLAYING;
            game_pkg::PLAYING:   if (f_playing)   next_state = game_pkg::GAME_OVER;
            game_pkg::GAME_OVER: if (f_game_over) next_state = game_pkg::GREETING;
            default:             next_state = game_pkg::GREETING;
        endcase
    end

    assign e_greeting  = (state == game_pkg::GREETING);
    assign e_playing   = (state == game_pkg::PLAYING);
    assign e_game_over = (state == game_pkg::GAME_OVER);

    // Idle phases drive zeros, so a plain OR merges them
    assign addr = ad_greeting | ad_playing | ad_game_over;
    assign data = dt_greeting | dt_playing | dt_game_over;
    assign wren = wr_greeting | wr_playing | wr_game_over;

    screen_fill #(
        .SCREEN_W (SCREEN_W),
        .SCREEN_H (SCREEN_H),
        .COLOR    (game_pkg::COLOR_GREETING)
    ) greeting_fill (
        .clock    (clock),
        .resetn   (resetn),
        .enable   (e_greeting),
        .finished (f_greeting),
        .addr     (ad_greeting),
        .data     (dt_greeting),
        .wren     (wr_greeting)
    );

    frame_sequencer #(
        .SCREEN_W    (SCREEN_W),
        .SCREEN_H    (SCREEN_H),
        .PLAYER_SIZE (PLAYER_SIZE)
    ) i_frame_sequencer (
        .clock     (clock),
        .resetn    (resetn),
        .enable    (e_playing),
        .finished  (f_playing),
        .player_x  (player_x),
        .player_y  (player_y),
        .addr      (ad_playing),
        .data      (dt_playing),
        .wren      (wr_playing),
        .q         (q),
        .vga_x     (vga_x),     // Only the playing phase drives VGA
        .vga_y     (vga_y),
        .vga_color (vga_color),
        .plot      (plot)
    );

    screen_fill #(
        .SCREEN_W (SCREEN_W),
        .SCREEN_H (SCREEN_H),
        .COLOR    (game_pkg::COLOR_GAME_OVER)
    ) game_over_fill (
        .clock    (clock),
        .resetn   (resetn),
        .enable   (e_game_over),
        .finished (f_game_over),
        .addr     (ad_game_over),
        .data     (dt_game_over),
        .wren     (wr_game_over)
    );

endmodule

/* playing/frame_sequencer.sv */
`timescale 1ns/1ps

module frame_sequencer #(
    parameter int SCREEN_W    = game_pkg::DEFAULT_SCREEN_W,
    parameter int SCREEN_H    = game_pkg::DEFAULT_SCREEN_H,
    parameter int PLAYER_SIZE = game_pkg::DEFAULT_PLAYER_SIZE
) (
    input  logic               clock,
    input  logic               resetn,
    input  logic               enable,
    output logic               finished,
    input  game_pkg::vga_x_t   player_x,
    input  game_pkg::vga_y_t   player_y,
    output game_pkg::fb_addr_t addr,
    output game_pkg::color_t   data,
    output logic               wren,
    input  game_pkg::color_t   q,
    output game_pkg::vga_x_t   vga_x,
    output game_pkg::vga_y_t   vga_y,
    output game_pkg::color_t   vga_color,
    output logic               plot
);

    typedef enum logic [2:0] {
        S_START,
        S_CLEAR,
        S_DRAW,
        S_SCAN,
        S_DONE
    } frame_state_t;

    frame_state_t state, next_state;

    logic f_clear, f_draw, f_scan;

    game_pkg::fb_addr_t ad_clear, ad_draw, ad_scan;
    game_pkg::color_t   dt_clear, dt_draw;
    logic               wr_clear, wr_draw;

    // Falls back to START whenever the phase is released
    always_ff @(posedge clock) begin
        if (!resetn || !enable)
            state <= S_START;
        else
            state <= next_state;
    end

    always_comb begin
        next_state = state;
        case (state)
            S_START: next_state = S_CLEAR;
            S_CLEAR: if (f_clear) next_state = S_DRAW;
            S_DRAW:  if (f_draw)  next_state = S_SCAN;
            S_SCAN:  if (f_scan)  next_state = S_DONE;
            S_DONE:  next_state = S_DONE;    // Wait for the top to move on
            default: next_state = S_START;
        endcase
    end

    assign finished = (state == S_DONE);

    assign addr = ad_clear | ad_draw | ad_scan;
    assign data = dt_clear | dt_draw;
    assign wren = wr_clear | wr_draw;

    screen_fill #(
        .SCREEN_W (SCREEN_W),
        .SCREEN_H (SCREEN_H),
        .COLOR    (game_pkg::COLOR_BACKGROUND)
    ) clear_fill (
        .clock    (clock),
        .resetn   (resetn),
        .enable   (state == S_CLEAR),
        .finished (f_clear),
        .addr     (ad_clear),
        .data     (dt_clear),
        .wren     (wr_clear)
    );

    sprite_fill #(
        .SCREEN_W    (SCREEN_W),
        .SCREEN_H    (SCREEN_H),
        .PLAYER_SIZE (PLAYER_SIZE)
    ) i_sprite_fill (
        .clock    (clock),
        .resetn   (resetn),
        .enable   (state == S_DRAW),
        .finished (f_draw),
        .origin_x (player_x),
        .origin_y (player_y),
        .addr     (ad_draw),
        .data     (dt_draw),
        .wren     (wr_draw)
    );

    scan_out #(
        .SCREEN_W (SCREEN_W),
        .SCREEN_H (SCREEN_H)
    ) i_scan_out (
        .clock     (clock),
        .resetn    (resetn),
        .enable    (state == S_SCAN),
        .finished  (f_scan),
        .addr      (ad_scan),
        .q         (q),
        .vga_x     (vga_x),
        .vga_y     (vga_y),
        .vga_color (vga_color),
        .plot      (plot)
    );

endmodule

/* playing/scan_out.sv */
`timescale 1ns/1ps

module scan_out #(
    parameter int SCREEN_W = game_pkg::DEFAULT_SCREEN_W,
    parameter int SCREEN_H = game_pkg::DEFAULT_SCREEN_H
) (
    input  logic               clock,
    input  logic               resetn,
    input  logic               enable,
    output logic               finished,
    output game_pkg::fb_addr_t addr,
    input  game_pkg::color_t   q,
    output game_pkg::vga_x_t   vga_x,
    output game_pkg::vga_y_t   vga_y,
    output game_pkg::color_t   vga_color,
    output logic               plot
);

    game_pkg::vga_x_t col;
    game_pkg::vga_y_t row;
    logic             active;       // Issuing read addresses
    logic             last_col;
    logic             last_pixel;

    logic             pipe_valid;   // A read is returning this cycle
    game_pkg::vga_x_t pipe_x;
    game_pkg::vga_y_t pipe_y;

    assign last_col   = (col == game_pkg::vga_x_t'(SCREEN_W - 1));
    assign last_pixel = last_col && (row == game_pkg::vga_y_t'(SCREEN_H - 1));

    always_ff @(posedge clock) begin
        if (!resetn || !enable) begin
            active     <= 1'b0;
            finished   <= 1'b0;
            pipe_valid <= 1'b0;
            col        <= '0;
            row        <= '0;
        end else begin
            pipe_valid <= active;
            if (active) begin
                if (last_pixel) begin
                    active <= 1'b0;
                end else if (last_col) begin
                    col <= '0;
                    row <= row + 1'b1;
                end else begin
                    col <= col + 1'b1;
                end
            end else if (pipe_valid) begin
                finished <= 1'b1;    // Last pixel has just been plotted
            end else if (!finished) begin
                active <= 1'b1;
            end
        end
    end

    // Coordinates follow the address by the RAM read latency
    always_ff @(posedge clock) begin
        pipe_x <= col;
        pipe_y <= row;
    end

    assign addr      = active ? game_pkg::pixel_addr(col, row, SCREEN_W) : '0;
    assign plot      = pipe_valid;
    assign vga_x     = pipe_valid ? pipe_x : '0;
    assign vga_y     = pipe_valid ? pipe_y : '0;
    assign vga_color = pipe_valid ? q : '0;

endmodule

/* playing/sprite_fill.sv */
`timescale 1ns/1ps

module sprite_fill #(
    parameter int SCREEN_W    = game_pkg::DEFAULT_SCREEN_W,
    parameter int SCREEN_H    = game_pkg::DEFAULT_SCREEN_H,
    parameter int PLAYER_SIZE = game_pkg::DEFAULT_PLAYER_SIZE
) (
    input  logic               clock,
    input  logic               resetn,
    input  logic               enable,
    output logic               finished,
    input  game_pkg::vga_x_t   origin_x,
    input  game_pkg::vga_y_t   origin_y,
    output game_pkg::fb_addr_t addr,
    output game_pkg::color_t   data,
    output logic               wren
);

    localparam int OFS_W = $clog2(PLAYER_SIZE + 1);
    localparam int XW    = $bits(game_pkg::vga_x_t) + 1;    // One spare bit for overflow
    localparam int YW    = $bits(game_pkg::vga_y_t) + 1;

    game_pkg::vga_x_t ox;
    game_pkg::vga_y_t oy;
    logic [OFS_W-1:0] dx, dy;
    logic             active;
    logic             last_dx;
    logic [XW-1:0]    px;
    logic [YW-1:0]    py;
    logic             on_screen;

    assign last_dx   = (dx == OFS_W'(PLAYER_SIZE - 1));
    assign px        = XW'(ox) + XW'(dx);
    assign py        = YW'(oy) + YW'(dy);
    assign on_screen = (px < SCREEN_W) && (py < SCREEN_H);

    // Origin sampled once, on the first enabled cycle
    always_ff @(posedge clock) begin
        if (enable && !active && !finished) begin
            ox <= origin_x;
            oy <= origin_y;
        end
    end

    always_ff @(posedge clock) begin
        if (!resetn || !enable) begin
            active   <= 1'b0;
            finished <= 1'b0;
            dx       <= '0;
            dy       <= '0;
        end else if (active) begin
            if (last_dx && dy == OFS_W'(PLAYER_SIZE - 1)) begin
                active   <= 1'b0;
                finished <= 1'b1;
            end else if (last_dx) begin
                dx <= '0;
                dy <= dy + 1'b1;
            end else begin
                dx <= dx + 1'b1;
            end
        end else if (!finished) begin
            active <= 1'b1;
        end
    end

    // Off-screen pixels still spend their cycle, just without a write
    assign wren = active && on_screen;
    assign addr = wren ? game_pkg::pixel_addr(game_pkg::vga_x_t'(px), game_pkg::vga_y_t'(py),
                                              SCREEN_W) : '0;
    assign data = wren ? game_pkg::COLOR_PLAYER : '0;

endmodule

/* src/screen_fill.sv */
`timescale 1ns/1ps

module screen_fill #(
    parameter int               SCREEN_W = game_pkg::DEFAULT_SCREEN_W,
    parameter int               SCREEN_H = game_pkg::DEFAULT_SCREEN_H,
    parameter game_pkg::color_t COLOR    = game_pkg::COLOR_BACKGROUND
) (
    input  logic               clock,
    input  logic               resetn,
    input  logic               enable,
    output logic               finished,
    output game_pkg::fb_addr_t addr,
    output game_pkg::color_t   data,
    output logic               wren
);

    game_pkg::vga_x_t col;
    game_pkg::vga_y_t row;
    logic             active;    // Walking the screen
    logic             last_col;
    logic             last_pixel;

    assign last_col   = (col == game_pkg::vga_x_t'(SCREEN_W - 1));
    assign last_pixel = last_col && (row == game_pkg::vga_y_t'(SCREEN_H - 1));

    always_ff @(posedge clock) begin
        if (!resetn || !enable) begin
            active   <= 1'b0;
            finished <= 1'b0;
            col      <= '0;
            row      <= '0;
        end else if (active) begin
            if (last_pixel) begin
                active   <= 1'b0;
                finished <= 1'b1;    // Held until enable drops
            end else if (last_col) begin
                col <= '0;
                row <= row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
        end else if (!finished) begin
            // First enabled cycle only arms the walk
            active <= 1'b1;
        end
    end

    assign wren = active;
    assign addr = active ? game_pkg::pixel_addr(col, row, SCREEN_W) : '0;
    assign data = active ? COLOR : '0;

endmodule

/* common/game_pkg.sv */
package game_pkg;

    // Pixel and address types shared by every phase
    typedef logic [11:0] color_t;    // 4 bits each of R, G, B
    typedef logic [16:0] fb_addr_t;
    typedef logic [8:0]  vga_x_t;
    typedef logic [7:0]  vga_y_t;

    typedef enum logic [1:0] {
        GREETING  = 2'd0,
        PLAYING   = 2'd1,
        GAME_OVER = 2'd2
    } game_state_t;

    // Paint colours
    localparam color_t COLOR_GREETING   = 12'h0F0;
    localparam color_t COLOR_BACKGROUND = 12'h113;
    localparam color_t COLOR_PLAYER     = 12'hFF0;
    localparam color_t COLOR_GAME_OVER  = 12'hF00;

    // Defaults for the screen geometry
    localparam int DEFAULT_SCREEN_W    = 320;
    localparam int DEFAULT_SCREEN_H    = 240;
    localparam int DEFAULT_PLAYER_SIZE = 8;

    // Row-major word address of a pixel
    function automatic fb_addr_t pixel_addr(
        input vga_x_t      x,
        input vga_y_t      y,
        input int unsigned width
    );
        int unsigned linear;
        linear = y * width + x;
        return fb_addr_t'(linear);
    endfunction

endpackage
